// File: src/kcpu_bus_pkg.sv
// kcpu bus definitions
// address and data widths of the system bus and the interrupt vector table

`default_nettype none

package kcpu_bus_pkg;

    // bus geometry
    localparam int addr_w = 16;    // byte address
    localparam int data_w = 8;     // one bus beat

    // interrupt vectors, each pointing at a big-endian word
    // at the top of the address map
    localparam logic [addr_w-1:0] vec_firq = 16'hFFF6;
    localparam logic [addr_w-1:0] vec_irq  = 16'hFFF8;
    localparam logic [addr_w-1:0] vec_nmi  = 16'hFFFC;
    localparam logic [addr_w-1:0] vec_rst  = 16'hFFFE;   // highest priority, fetched at power up

endpackage

`default_nettype wire

// File: src/kcpu_ctrl_pkg.sv
// kcpu memory controller definitions
// interrupt request codes, index offset size and the fetched word layout

`default_nettype none

package kcpu_ctrl_pkg;

    // one-hot interrupt request, all zero means no request
    // bit 0 irq, bit 1 firq, bit 2 nmi, bit 3 reset
    typedef logic [3:0] intvec_t;

    localparam int ofs_w = 8;    // signed offset of the index unit

    // opcode and postbyte as the first and second byte read
    typedef struct packed {
        logic [kcpu_bus_pkg::data_w-1:0] opcode;      // first byte, high half
        logic [kcpu_bus_pkg::data_w-1:0] postbyte;    // second byte, low half
    } op_pair_t;

    // a fetched word, seen either as a 16-bit operand or as an opcode pair
    typedef union packed {
        logic [2*kcpu_bus_pkg::data_w-1:0] word;   // big-endian operand
        op_pair_t                          pair;
    } fetch_word_u;

endpackage

`default_nettype wire

// File: src/kcpu_cen_gen.sv
// kcpu clock enables
// bus enable cen2 every CEN_DIV clocks and the half-rate cpu enable cen

`timescale 1ns/1ps
`default_nettype none

module kcpu_cen_gen #(
    parameter int CEN_DIV = 2    // clk cycles per cen2
) (
    input  logic clk,
    input  logic rst,
    output logic cen2,    // bus enable, one clk wide
    output logic cen      // every second cen2
);
    localparam int CW = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;

    logic [CW-1:0] cnt;
    logic          half;   // toggles on each cen2
    logic          tick;

    assign tick = (cnt == CW'(CEN_DIV - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= '0;
            cen2 <= 1'b0;
            cen  <= 1'b0;
            half <= 1'b0;
        end else begin
            cnt  <= tick ? '0 : cnt + 1'b1;
            cen2 <= tick;
            cen  <= tick && half;   // lands on the second bus beat
            if (tick) half <= ~half;
        end
    end

endmodule

`default_nettype wire

// File: src/kcpu_index_unit.sv
// kcpu index unit
// registers X or Y plus a sign-extended offset as the indexed address

`timescale 1ns/1ps
`default_nettype none

module kcpu_index_unit (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             cen2,
    input  logic [kcpu_bus_pkg::addr_w-1:0]  regs_x,
    input  logic [kcpu_bus_pkg::addr_w-1:0]  regs_y,
    input  logic                             idx_base_y,   // base is Y, else X
    input  logic [kcpu_ctrl_pkg::ofs_w-1:0]  idx_ofs,      // two's complement
    output logic [kcpu_bus_pkg::addr_w-1:0]  idx_addr
);
    import kcpu_bus_pkg::*;
    import kcpu_ctrl_pkg::*;

    logic [addr_w-1:0] base;
    logic [addr_w-1:0] ofs_ext;

    assign base    = idx_base_y ? regs_y : regs_x;
    assign ofs_ext = {{(addr_w - ofs_w){idx_ofs[ofs_w-1]}}, idx_ofs};

    // sum wraps modulo 2^addr_w
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx_addr <= '0;
        end else if (cen2) begin
            idx_addr <= base + ofs_ext;   // ready on the next tick
        end
    end

endmodule

`default_nettype wire

// File: src/kcpu_stack_unit.sv
// kcpu stack unit
// system stack pointer S, pre-decremented by the push size on every push

`timescale 1ns/1ps
`default_nettype none

module kcpu_stack_unit #(
    parameter logic [kcpu_bus_pkg::addr_w-1:0] SP_RESET = 16'h0200
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             cen2,
    input  logic                             psh_en,   // push on this tick
    input  logic                             mem16,    // word push
    input  logic                             halt,
    output logic [kcpu_bus_pkg::addr_w-1:0]  psh_addr
);
    import kcpu_bus_pkg::*;

    logic [addr_w-1:0] sp;
    logic [addr_w-1:0] sp_dec;

    // a word occupies S and S+1 after the decrement, high byte at S
    assign sp_dec = sp - (mem16 ? addr_w'(2) : addr_w'(1));

    // the controller latches this on the push tick itself,
    // so it already carries the decremented value
    assign psh_addr = psh_en ? sp_dec : sp;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp <= SP_RESET;
        end else if (cen2 && !halt && psh_en) begin
            sp <= sp_dec;
        end
    end

endmodule

`default_nettype wire

// File: src/kcpu_memctrl.sv
// kcpu memory controller
// address mux, 8/16-bit bus sequencing, opcode capture and vector fetch

`timescale 1ns/1ps
`default_nettype none

module kcpu_memctrl (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cen2,     // bus beat
    input  logic                               cen,      // cpu step
    // address sources
    input  logic [kcpu_bus_pkg::addr_w-1:0]    pc,
    input  logic [kcpu_bus_pkg::data_w-1:0]    dp,
    input  logic [kcpu_bus_pkg::addr_w-1:0]    idx_addr,
    input  logic [kcpu_bus_pkg::addr_w-1:0]    psh_addr,
    input  logic [kcpu_bus_pkg::addr_w-1:0]    regs_x,
    input  logic [kcpu_bus_pkg::addr_w-1:0]    regs_y,
    // bus side
    input  logic [kcpu_bus_pkg::data_w-1:0]    din,
    output logic [kcpu_bus_pkg::data_w-1:0]    dout,
    output logic [kcpu_bus_pkg::addr_w-1:0]    addr,
    output logic                               we,
    // fetch results
    output logic [kcpu_bus_pkg::data_w-1:0]    op,
    output kcpu_ctrl_pkg::fetch_word_u         data,
    output logic                               busy,     // first beat of a word pending
    output logic                               up_pc,    // vector word ready for the pc
    output logic                               is_op,    // current access is an opcode fetch
    // access control
    input  logic                               mem16,
    input  logic                               halt,     // freeze everything
    input  logic                               idx_en,
    input  logic                               psh_en,
    input  logic                               dp_en,
    input  logic                               addrx,
    input  logic                               addry,
    input  logic                               opd,      // operand, not an opcode
    input  kcpu_ctrl_pkg::intvec_t             intvec,
    input  logic [2*kcpu_bus_pkg::data_w-1:0]  alu_dout,
    input  logic                               wrq
);
    import kcpu_bus_pkg::*;
    import kcpu_ctrl_pkg::*;

    intvec_t int_code;   // latched request while its vector is read
    logic    lo_beat;    // previous beat was the low half of a word

    function automatic logic [addr_w-1:0] vec_addr(input intvec_t code);
        case (code)
            4'b0001: vec_addr = vec_irq;
            4'b0010: vec_addr = vec_firq;
            4'b0100: vec_addr = vec_nmi;
            default: vec_addr = vec_rst;   // reset and malformed codes
        endcase
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr     <= '0;
            busy     <= 1'b0;
            we       <= 1'b0;
            up_pc    <= 1'b0;
            is_op    <= 1'b0;
            int_code <= '0;
            lo_beat  <= 1'b0;
        end else if (cen2 && !halt) begin
            up_pc <= 1'b0;   // single tick strobes
            we    <= 1'b0;
            if (busy) begin
                // first beat of a word, high byte at the lower address
                data.pair.opcode <= din;
                if (is_op) op <= din;
                addr    <= addr + 1'b1;
                busy    <= 1'b0;
                lo_beat <= 1'b1;
                dout    <= alu_dout[data_w-1:0];   // low byte goes out second
                we      <= we;                     // a word write spans both beats
            end else if (!up_pc) begin
                // byte from the previous address, low half of any word
                data.pair.postbyte <= din;
                if (is_op && !lo_beat) op <= din;
                lo_beat <= 1'b0;
                if (int_code != '0) begin
                    // vector word complete, address stays put for the pc load
                    up_pc    <= 1'b1;
                    int_code <= '0;
                    is_op    <= 1'b0;
                end else if (intvec != '0) begin
                    addr     <= vec_addr(intvec);
                    int_code <= intvec;
                    busy     <= 1'b1;   // vectors are always words
                    is_op    <= 1'b0;
                end else begin
                    is_op <= 1'b0;
                    if (addry) begin
                        addr <= regs_y;
                    end else if (addrx) begin
                        addr <= regs_x;
                    end else if (psh_en) begin
                        addr <= psh_addr;   // already decremented
                    end else if (idx_en) begin
                        addr <= idx_addr;
                    end else if (dp_en) begin
                        addr <= {dp, data.pair.postbyte};   // page plus postbyte
                    end else begin
                        addr  <= pc;
                        is_op <= !opd;
                    end
                    busy <= mem16;
                    // high byte first on a word write
                    dout <= mem16 ? alu_dout[2*data_w-1:data_w] : alu_dout[data_w-1:0];
                    we   <= wrq && cen;   // writes only start on a cpu step
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/kcpu_bus_ram.sv
// kcpu bus memory
// byte-wide RAM standing in for the system bus, upper address bits ignored

`timescale 1ns/1ps
`default_nettype none

module kcpu_bus_ram #(
    parameter int RAM_AW = 10    // 2^RAM_AW bytes
) (
    input  logic                             clk,
    input  logic                             cen2,
    input  logic [kcpu_bus_pkg::addr_w-1:0]  addr,
    input  logic                             we,
    input  logic [kcpu_bus_pkg::data_w-1:0]  dout,   // data from the controller
    output logic [kcpu_bus_pkg::data_w-1:0]  din     // data to the controller
);
    import kcpu_bus_pkg::*;

    logic [data_w-1:0] mem [2**RAM_AW];
    logic [RAM_AW-1:0] ram_a;

    // vectors at the top of the map alias onto the top bytes here
    assign ram_a = addr[RAM_AW-1:0];

    assign din = mem[ram_a];   // asynchronous read

    always_ff @(posedge clk) begin
        if (cen2 && we) begin
            mem[ram_a] <= dout;   // one byte per beat
        end
    end

endmodule

`default_nettype wire

// File: src/kcpu_mem_sys.sv
// kcpu memory subsystem
// clock enables, index and stack units, memory controller and bus RAM

`timescale 1ns/1ps
`default_nettype none

module kcpu_mem_sys #(
    parameter int                              CEN_DIV  = 2,
    parameter int                              RAM_AW   = 10,
    parameter logic [kcpu_bus_pkg::addr_w-1:0] SP_RESET = 16'h0200
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [kcpu_bus_pkg::addr_w-1:0]    pc,
    input  logic [kcpu_bus_pkg::data_w-1:0]    dp,
    input  logic [kcpu_bus_pkg::addr_w-1:0]    regs_x,
    input  logic [kcpu_bus_pkg::addr_w-1:0]    regs_y,
    input  logic                               idx_base_y,
    input  logic [kcpu_ctrl_pkg::ofs_w-1:0]    idx_ofs,
    input  logic                               mem16,
    input  logic                               halt,
    input  logic                               idx_en,
    input  logic                               psh_en,
    input  logic                               dp_en,
    input  logic                               addrx,
    input  logic                               addry,
    input  logic                               opd,
    input  kcpu_ctrl_pkg::intvec_t             intvec,
    input  logic [2*kcpu_bus_pkg::data_w-1:0]  alu_dout,
    input  logic                               wrq,
    output logic [kcpu_bus_pkg::addr_w-1:0]    addr,
    output logic [kcpu_bus_pkg::data_w-1:0]    op,
    output kcpu_ctrl_pkg::fetch_word_u         data,
    output logic                               busy,
    output logic                               up_pc,
    output logic                               is_op,
    output logic                               cen2
);
    import kcpu_bus_pkg::*;

    logic              cen;
    logic [addr_w-1:0] idx_addr;
    logic [addr_w-1:0] psh_addr;
    logic [data_w-1:0] din;    // ram to controller
    logic [data_w-1:0] dout;   // controller to ram
    logic              we;

    kcpu_cen_gen #(.CEN_DIV(CEN_DIV)) cen_gen_i (
        .clk(clk), .rst(rst), .cen2(cen2), .cen(cen)
    );

    kcpu_index_unit index_i (
        .clk(clk), .rst(rst), .cen2(cen2), .regs_x(regs_x), .regs_y(regs_y),
        .idx_base_y(idx_base_y), .idx_ofs(idx_ofs), .idx_addr(idx_addr)
    );

    kcpu_stack_unit #(.SP_RESET(SP_RESET)) stack_i (
        .clk(clk), .rst(rst), .cen2(cen2), .psh_en(psh_en), .mem16(mem16),
        .halt(halt), .psh_addr(psh_addr)
    );

    kcpu_memctrl memctrl_i (
        .clk(clk), .rst(rst), .cen2(cen2), .cen(cen),
        .pc(pc), .dp(dp), .idx_addr(idx_addr), .psh_addr(psh_addr),
        .regs_x(regs_x), .regs_y(regs_y),
        .din(din), .dout(dout), .addr(addr), .we(we),
        .op(op), .data(data), .busy(busy), .up_pc(up_pc), .is_op(is_op),
        .mem16(mem16), .halt(halt), .idx_en(idx_en), .psh_en(psh_en),
        .dp_en(dp_en), .addrx(addrx), .addry(addry), .opd(opd),
        .intvec(intvec), .alu_dout(alu_dout), .wrq(wrq)
    );

    kcpu_bus_ram #(.RAM_AW(RAM_AW)) ram_i (
        .clk(clk), .cen2(cen2), .addr(addr), .we(we), .dout(dout), .din(din)
    );

endmodule

`default_nettype wire

// File: testbench/kcpu_mem_sys_tb.sv
// kcpu memory subsystem testbench
// table-driven reads, writes, pushes, vectors and halt against a byte-array RAM model

`timescale 1ns/1ps
`default_nettype none

module kcpu_mem_sys_tb;
    import kcpu_bus_pkg::*;
    import kcpu_ctrl_pkg::*;

    localparam int CEN_DIV = 2;
    localparam int RAM_AW  = 10;
    localparam logic [15:0] SP_RESET = 16'h0200;
    localparam int N_STEP  = 16;
    localparam int LIMIT   = N_STEP * 4 * CEN_DIV + 50;   // about four bus ticks per step

    // src: 0 pc, 1 x, 2 y, 3 indexed, 4 push, 5 direct page, 6 vector
    typedef struct packed {
        logic [2:0]  src;
        logic        mem16;
        logic        wrq;
        logic        opd;
        logic [3:0]  ivec;
        logic        hlt;
        logic        base_y;
        logic [15:0] reg_v;   // pointer or index base
        logic [15:0] pc_v;
        logic [7:0]  dp_v;
    } step_t;

    logic clk, rst;
    logic [15:0] pc, regs_x, regs_y, alu_dout, addr;
    logic [7:0]  dp, idx_ofs, op;
    logic idx_base_y, mem16, halt, idx_en, psh_en, dp_en, addrx, addry, opd, wrq;
    logic busy, up_pc, is_op, cen2;
    intvec_t     intvec;
    fetch_word_u data;

    step_t       tbl [N_STEP];
    logic [7:0]  model [2**RAM_AW];   // expected RAM contents
    logic [31:0] lfsr = 32'h9ab2_c1fb;
    int          cycles = 0;

    kcpu_mem_sys #(.CEN_DIV(CEN_DIV), .RAM_AW(RAM_AW), .SP_RESET(SP_RESET)) dut_i (
        .clk(clk), .rst(rst), .pc(pc), .dp(dp), .regs_x(regs_x), .regs_y(regs_y),
        .idx_base_y(idx_base_y), .idx_ofs(idx_ofs), .mem16(mem16), .halt(halt),
        .idx_en(idx_en), .psh_en(psh_en), .dp_en(dp_en), .addrx(addrx), .addry(addry),
        .opd(opd), .intvec(intvec), .alu_dout(alu_dout), .wrq(wrq), .addr(addr),
        .op(op), .data(data), .busy(busy), .up_pc(up_pc), .is_op(is_op), .cen2(cen2)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("run did not finish within %0d clock cycles", LIMIT);
            $display("Test failed");
            $fatal(1);
        end
    end

    // galois lfsr, one shift per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [7:0] mbyte(input logic [15:0] a);
        return model[a[RAM_AW-1:0]];
    endfunction

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // returns 1 ns after the edge that raises cen2, so the next edge is a bus tick
    task automatic tick_step;
        int n;
        n = 0;
        @(posedge clk);
        #1;
        n++;
        while (!cen2) begin
            @(posedge clk);
            #1;
            n++;
        end
        check("cen2 period", n, CEN_DIV);   // one clk wide, every CEN_DIV clocks
    endtask

    // plain operand read from pc between the steps under test
    task automatic drive_idle;
        addrx  = 0;
        addry  = 0;
        idx_en = 0;
        psh_en = 0;
        dp_en  = 0;
        mem16  = 0;
        wrq    = 0;
        opd    = 1;
        intvec = '0;
        halt   = 0;
    endtask

    initial begin
        logic [15:0] ea, sp_m, hold_a;
        logic [7:0]  exp_op, post;
        fetch_word_u hold_d;
        step_t       e;

        //            src mem16 wrq opd ivec hlt by reg_v     pc_v      dp
        tbl[0]  = '{3'd1, 1, 1, 1, 4'h0, 0, 0, 16'h0120, 16'h0080, 8'h00};  // word via x
        tbl[1]  = '{3'd2, 1, 0, 1, 4'h0, 0, 0, 16'h0120, 16'h0080, 8'h00};  // back via y
        tbl[2]  = '{3'd0, 0, 0, 0, 4'h0, 0, 0, 16'h0000, 16'h0040, 8'h00};  // opcode
        tbl[3]  = '{3'd0, 0, 0, 1, 4'h0, 0, 0, 16'h0000, 16'h0041, 8'h00};  // operand
        tbl[4]  = '{3'd3, 0, 0, 1, 4'h0, 0, 0, 16'h0100, 16'h0044, 8'h00};
        tbl[5]  = '{3'd3, 0, 0, 1, 4'h0, 0, 1, 16'h0003, 16'h0047, 8'h00};  // may wrap
        tbl[6]  = '{3'd5, 0, 0, 1, 4'h0, 0, 0, 16'h0000, 16'h0080, 8'h02};
        tbl[7]  = '{3'd4, 1, 1, 1, 4'h0, 0, 0, 16'h0000, 16'h0080, 8'h00};
        tbl[8]  = '{3'd4, 1, 1, 1, 4'h0, 0, 0, 16'h0000, 16'h0080, 8'h00};
        tbl[9]  = '{3'd2, 1, 0, 1, 4'h0, 0, 0, 16'h01FE, 16'h0080, 8'h00};
        tbl[10] = '{3'd2, 1, 0, 1, 4'h0, 0, 0, 16'h01FC, 16'h0080, 8'h00};
        tbl[11] = '{3'd6, 1, 0, 1, 4'h1, 0, 0, 16'h0000, 16'h0080, 8'h00};  // irq
        tbl[12] = '{3'd6, 1, 0, 1, 4'h2, 0, 0, 16'h0000, 16'h0080, 8'h00};  // firq
        tbl[13] = '{3'd6, 1, 0, 1, 4'h4, 0, 0, 16'h0000, 16'h0080, 8'h00};  // nmi
        tbl[14] = '{3'd6, 1, 0, 1, 4'h8, 0, 0, 16'h0000, 16'h0080, 8'h00};  // reset
        tbl[15] = '{3'd1, 1, 0, 1, 4'h0, 1, 0, 16'h0120, 16'h0080, 8'h00};  // halted word

        // fill pattern mixes the low byte with the upper address bits
        for (int a = 0; a < 2**RAM_AW; a++) begin
            model[a] = a[7:0] ^ {a[9:8], a[9:8], a[9:8], a[9:8]} ^ 8'h5A;
            dut_i.ram_i.mem[a] = model[a];
        end

        rst        = 1;
        pc         = '0;
        dp         = '0;
        regs_x     = '0;
        regs_y     = '0;
        alu_dout   = '0;
        idx_base_y = 0;
        idx_ofs    = '0;
        drive_idle();
        repeat (5) @(posedge clk);
        #1 rst = 0;

        sp_m   = SP_RESET;
        exp_op = '0;
        post   = '0;
        for (int i = 0; i < N_STEP; i++) begin
            e = tbl[i];
            drive_idle();
            pc = e.pc_v;
            dp = e.dp_v;
            if (e.src == 3'd1) regs_x = e.reg_v;
            if (e.src == 3'd2) regs_y = e.reg_v;
            if (e.src == 3'd3) begin
                idx_base_y = e.base_y;
                idx_ofs    = rand_bits(8);
                if (e.base_y) regs_y = e.reg_v;
                else regs_x = e.reg_v;
            end
            if (e.wrq) alu_dout = rand_bits(16);
            tick_step();   // index unit registers its sum here
            while (e.wrq && !dut_i.cen) tick_step();

            case (e.src)
                3'd0: ea = e.pc_v;
                3'd1, 3'd2: ea = e.reg_v;
                3'd3: ea = e.reg_v + {{8{idx_ofs[7]}}, idx_ofs};
                3'd4: begin
                    sp_m = sp_m - 16'd2;   // word push, pre-decrement
                    ea   = sp_m;
                end
                3'd5: ea = {e.dp_v, post};
                default: ea = (e.ivec == 4'h1) ? 16'hFFF8 : (e.ivec == 4'h2) ? 16'hFFF6 :
                              (e.ivec == 4'h4) ? 16'hFFFC : 16'hFFFE;
            endcase
            addrx  = (e.src == 3'd1);
            addry  = (e.src == 3'd2);
            idx_en = (e.src == 3'd3);
            psh_en = (e.src == 3'd4);
            dp_en  = (e.src == 3'd5);
            mem16  = e.mem16;
            wrq    = e.wrq;
            opd    = e.opd;
            intvec = e.ivec;
            tick_step();   // address tick
            check("addr", addr, ea);
            check("busy", busy, e.mem16);
            check("up_pc", up_pc, 0);
            check("is_op", is_op, (e.src == 3'd0) && !e.opd);   // pc fetches only
            drive_idle();

            if (e.hlt) begin
                hold_a = addr;
                hold_d = data;
                halt = 1;
                repeat (3) begin
                    tick_step();
                    check("addr", addr, hold_a);
                    check("data", data.word, hold_d.word);
                    check("busy", busy, 1);
                end
                halt = 0;
            end
            if (e.mem16) begin
                tick_step();   // high byte beat
                check("addr", addr, ea + 16'd1);
                check("busy", busy, 0);
                check("up_pc", up_pc, 0);
            end
            tick_step();   // low byte lands
            if (!e.wrq) begin
                if (e.mem16) check("data", data.word, {mbyte(ea), mbyte(ea + 16'd1)});
                else check("data.postbyte", data.pair.postbyte, mbyte(ea));
            end
            if (e.src == 3'd0) begin
                if (!e.opd) exp_op = mbyte(ea);
                check("op", op, exp_op);
            end
            check("up_pc", up_pc, e.src == 3'd6);
            if (e.src == 3'd6) begin
                tick_step();
                check("up_pc", up_pc, 0);   // one pulse only
                check("addr", addr, ea + 16'd1);
            end
            if (e.wrq) begin
                model[ea[RAM_AW-1:0]] = e.mem16 ? alu_dout[15:8] : alu_dout[7:0];
                if (e.mem16) model[ea[RAM_AW-1:0] + 1'b1] = alu_dout[7:0];
            end
            post = mbyte(e.pc_v);   // next page offset comes from the idle pc fetch
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
src/kcpu_bus_pkg.sv
src/kcpu_ctrl_pkg.sv
src/kcpu_cen_gen.sv
src/kcpu_index_unit.sv
src/kcpu_stack_unit.sv
src/kcpu_memctrl.sv
src/kcpu_bus_ram.sv
src/kcpu_mem_sys.sv
testbench/kcpu_mem_sys_tb.sv
